/* rtl/spi_array_settings.svh */
`ifndef SPI_ARRAY_SETTINGS_SVH
`define SPI_ARRAY_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// SPI array build settings
////////////////////////////////////////////////////////////////////////////

// Number of SPI channels
`define SPI_N_CH 4

// Bits per frame
`define SPI_WIDTH 32

// CLK50MHZ cycles per SPI bit
// Even and at least 2
// 4 gives 12.5 MHz and keeps MOSI one clock ahead of the rising edge
`define SPI_SCK_DIV 4

`endif

/* rtl/spi_array_pkg.sv */
`default_nettype none

package spi_array_pkg;

`include "spi_array_settings.svh"

	// One frame word
	typedef logic [`SPI_WIDTH-1:0] word_t;

	// Channel index
	typedef logic [$clog2(`SPI_N_CH)-1:0] chan_t;

	// Received frame with its source channel
	typedef struct packed {
		chan_t chan;
		word_t word;
	} rx_result_t;

endpackage

`default_nettype wire

/* rtl/spi_chan_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface spi_chan_if;

	// Start strobe from the dispatcher
	logic                  trig;
	// Word to send, valid with trig
	spi_array_pkg::word_t  tx_word;
	// Received word, valid while done is high
	spi_array_pkg::word_t  rx_word;
	// End of frame strobe from the engine
	logic                  done;

	modport dispatch (
		output trig,
		output tx_word
	);

	modport engine (
		input  trig,
		input  tx_word,
		output rx_word,
		output done
	);

	modport collect (
		input  rx_word,
		input  done
	);

endinterface

`default_nettype wire

/* rtl/sck_tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_array_settings.svh"

module sck_tick_gen (
	input  logic CLK50MHZ,
	input  logic RST,
	output logic tick,
	output logic spi_sck
);

	localparam int CNT_W = $clog2(`SPI_SCK_DIV);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SPI_SCK_DIV - 1);
	localparam logic [CNT_W-1:0] SCK_RISE = CNT_W'(`SPI_SCK_DIV / 2 - 1);

	// Bit phase counter shared by every channel
	logic [CNT_W-1:0] cnt;

	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			cnt     <= '0;
			tick    <= 1'b0;
			spi_sck <= 1'b0;
		end else begin
			if (cnt == CNT_LAST) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
			// Tick on the first clock of the low half
			tick <= (cnt == CNT_LAST);
			// SCK high for the second half of the bit
			// Outputs are registered so compare against the next phase
			spi_sck <= (cnt >= SCK_RISE) && (cnt != CNT_LAST);
		end
	end

endmodule

`default_nettype wire

/* rtl/spi_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_array_settings.svh"

module spi_dispatch (
	input  logic                  CLK50MHZ,
	input  logic                  RST,
	input  logic                  start,
	input  spi_array_pkg::chan_t  start_chan,
	input  spi_array_pkg::word_t  start_word,
	input  logic [`SPI_N_CH-1:0]  busy,
	output logic                  start_drop,
	spi_chan_if.dispatch          chan [`SPI_N_CH]
);

	// One trigger strobe per channel
	logic [`SPI_N_CH-1:0] trig_q;
	// Word for the triggered channel
	spi_array_pkg::word_t word_q;
	// Channel already running or about to start
	logic                 blocked;

	// A trig still in flight counts as busy too
	// The engine raises busy only one cycle later
	assign blocked = busy[start_chan] || trig_q[start_chan];

	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			trig_q     <= '0;
			start_drop <= 1'b0;
		end else begin
			trig_q     <= '0;
			start_drop <= 1'b0;
			if (start) begin
				if (blocked) begin
					start_drop <= 1'b1;
				end else begin
					trig_q[start_chan] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLK50MHZ) begin
		if (start && !blocked) begin
			word_q <= start_word;
		end
	end

	// Word fans out to all channels
	// Only the strobed one takes it
	for (genvar i = 0; i < `SPI_N_CH; i++) begin : g_chan
		assign chan[i].trig    = trig_q[i];
		assign chan[i].tx_word = word_q;
	end

endmodule

`default_nettype wire

/* rtl/spi_shift_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_array_settings.svh"

module spi_shift_engine (
	input  logic        CLK50MHZ,
	input  logic        RST,
	input  logic        tick,
	input  logic        spi_sck,
	input  logic        miso,
	output logic        mosi,
	output logic        cs_n,
	output logic        busy,
	spi_chan_if.engine  chan
);

	localparam int CNT_W = $clog2(`SPI_WIDTH);
	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`SPI_WIDTH - 1);

	typedef enum logic [1:0] {
		ST_WAIT,
		ST_SEND,
		ST_DONE
	} state_t;

	state_t               state;
	logic                 pending;
	logic [CNT_W-1:0]     bit_cnt;
	logic                 last_bit;
	logic                 frame_start;
	logic                 shift_out;
	logic                 miso_q;
	logic                 done;
	spi_array_pkg::word_t tx_sr;
	spi_array_pkg::word_t rx_sr;

	assign last_bit    = (bit_cnt == LAST_BIT);
	assign frame_start = tick && (state == ST_WAIT) && pending;
	// MSB goes out at frame start and the rest on all but the last sample
	assign shift_out   = frame_start || (tick && (state == ST_SEND) && !last_bit);
	assign busy        = pending || (state != ST_WAIT);

	assign chan.rx_word = rx_sr;
	assign chan.done    = done;

	////////////////////////////////////////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			state   <= ST_WAIT;
			pending <= 1'b0;
			bit_cnt <= '0;
			cs_n    <= 1'b1;
			mosi    <= 1'b0;
			done    <= 1'b0;
		end else begin
			done <= 1'b0;
			if (tick) begin
				case (state)
					ST_WAIT: if (pending) begin
						state   <= ST_SEND;
						pending <= 1'b0;
						cs_n    <= 1'b0;
						bit_cnt <= '0;
					end
					ST_SEND: begin
						bit_cnt <= bit_cnt + 1'b1;
						// Deselect right after the last sample
						// so the slave sees no extra rising edge
						if (last_bit) begin
							state <= ST_DONE;
							cs_n  <= 1'b1;
						end
					end
					ST_DONE: begin
						state <= ST_WAIT;
						done  <= 1'b1;
					end
					default: state <= ST_WAIT;
				endcase
			end
			if (shift_out) begin
				mosi <= tx_sr[`SPI_WIDTH-1];
			end else if (tick) begin
				mosi <= 1'b0;
			end
			// Trigger between ticks waits here
			if (chan.trig) begin
				pending <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Shift registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (chan.trig) begin
			tx_sr <= chan.tx_word;
		end else if (shift_out) begin
			tx_sr <= tx_sr << 1;
		end
		if (frame_start) begin
			rx_sr <= '0;
		end else if (tick && (state == ST_SEND)) begin
			rx_sr <= {rx_sr[`SPI_WIDTH-2:0], miso_q};
		end
		// MISO as held over the high half
		// Slave shifts on the falling edge that opens the tick cycle
		if (spi_sck) begin
			miso_q <= miso;
		end
	end

endmodule

`default_nettype wire

/* rtl/spi_collect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_array_settings.svh"

module spi_collect (
	input  logic                       CLK50MHZ,
	input  logic                       RST,
	spi_chan_if.collect                chan [`SPI_N_CH],
	output logic                       rx_valid,
	output spi_array_pkg::rx_result_t  rx_result
);

	logic [`SPI_N_CH-1:0] done_vec;
	logic [`SPI_N_CH-1:0] pend;
	logic [`SPI_N_CH-1:0] req;
	logic [`SPI_N_CH-1:0] grant;
	spi_array_pkg::word_t rx_in [`SPI_N_CH];
	spi_array_pkg::word_t held [`SPI_N_CH];
	spi_array_pkg::chan_t sel;
	spi_array_pkg::word_t sel_word;

	for (genvar i = 0; i < `SPI_N_CH; i++) begin : g_chan
		assign done_vec[i] = chan[i].done;
		assign rx_in[i]    = chan[i].rx_word;
	end

	// A fresh done competes in its own cycle
	assign req = pend | done_vec;

	////////////////////////////////////////////////////////////////////////////
	// Lowest channel first
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		grant = '0;
		sel   = '0;
		for (int k = `SPI_N_CH - 1; k >= 0; k--) begin
			if (req[k]) begin
				grant = '0;
				grant[k] = 1'b1;
				sel = spi_array_pkg::chan_t'(k);
			end
		end
		// Stored copy if pending else straight from the engine
		sel_word = pend[sel] ? held[sel] : rx_in[sel];
	end

	always_ff @(posedge CLK50MHZ) begin
		if (!RST) begin
			pend     <= '0;
			rx_valid <= 1'b0;
		end else begin
			pend     <= req & ~grant;
			rx_valid <= |req;
		end
	end

	always_ff @(posedge CLK50MHZ) begin
		for (int k = 0; k < `SPI_N_CH; k++) begin
			if (done_vec[k]) begin
				held[k] <= rx_in[k];
			end
		end
		rx_result.chan <= sel;
		rx_result.word <= sel_word;
	end

endmodule

`default_nettype wire

/* rtl/spi_array_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_array_settings.svh"

module spi_array_top (
	input  logic                  CLK50MHZ,
	input  logic                  RST,
	input  logic                  start,
	input  spi_array_pkg::chan_t  start_chan,
	input  spi_array_pkg::word_t  start_word,
	output logic                  start_drop,
	output logic [`SPI_N_CH-1:0]  busy,
	output logic                  spi_sck,
	output logic [`SPI_N_CH-1:0]  spi_cs_n,
	output logic [`SPI_N_CH-1:0]  spi_mosi,
	input  logic [`SPI_N_CH-1:0]  spi_miso,
	output logic                  rx_valid,
	output spi_array_pkg::chan_t  rx_chan,
	output spi_array_pkg::word_t  rx_word
);

	logic                       tick;
	spi_array_pkg::rx_result_t  rx_result;

	// Per channel links between dispatcher engines and collector
	spi_chan_if chan_if [`SPI_N_CH] ();

	assign rx_chan = rx_result.chan;
	assign rx_word = rx_result.word;

	// Shared bit phase
	sck_tick_gen u_tick (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.tick     (tick),
		.spi_sck  (spi_sck)
	);

	spi_dispatch u_dispatch (
		.CLK50MHZ   (CLK50MHZ),
		.RST        (RST),
		.start      (start),
		.start_chan (start_chan),
		.start_word (start_word),
		.busy       (busy),
		.start_drop (start_drop),
		.chan       (chan_if)
	);

	// One engine per slave
	for (genvar i = 0; i < `SPI_N_CH; i++) begin : g_eng
		spi_shift_engine u_eng (
			.CLK50MHZ (CLK50MHZ),
			.RST      (RST),
			.tick     (tick),
			.spi_sck  (spi_sck),
			.miso     (spi_miso[i]),
			.mosi     (spi_mosi[i]),
			.cs_n     (spi_cs_n[i]),
			.busy     (busy[i]),
			.chan     (chan_if[i])
		);
	end

	spi_collect u_collect (
		.CLK50MHZ  (CLK50MHZ),
		.RST       (RST),
		.chan      (chan_if),
		.rx_valid  (rx_valid),
		.rx_result (rx_result)
	);

endmodule

`default_nettype wire

/* bench/spi_array_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_array_settings.svh"

module spi_array_chk (
	input  logic                  CLK50MHZ,
	input  logic                  RST,
	input  logic [`SPI_N_CH-1:0]  busy,
	input  logic                  spi_sck,
	input  logic [`SPI_N_CH-1:0]  spi_cs_n,
	input  logic                  rx_valid,
	input  spi_array_pkg::chan_t  rx_chan
);

	// Select only drops on a channel that holds a frame
	for (genvar i = 0; i < `SPI_N_CH; i++) begin : g_cs
		cs_fall_busy: assert property (@(posedge CLK50MHZ) disable iff (!RST)
			$fell(spi_cs_n[i]) |-> busy[i])
			else $error("chip select %0d fell while its channel was idle", i);
	end

	// Same channel in two adjacent cycles is a duplicated result
	rx_once: assert property (@(posedge CLK50MHZ) disable iff (!RST)
		(rx_valid && $past(rx_valid)) |-> (rx_chan != $past(rx_chan)))
		else $error("result for channel %0d reported twice in a row", rx_chan);

	// Half a bit is SPI_SCK_DIV/2 clocks, two at the 12.5 MHz setting
	sck_half: assert property (@(posedge CLK50MHZ) disable iff (!RST)
		(spi_sck != $past(spi_sck)) |=> (spi_sck == $past(spi_sck)))
		else $error("spi_sck toggled twice within half a bit period");

endmodule

bind spi_array_top spi_array_chk u_chk (
	.CLK50MHZ (CLK50MHZ),
	.RST      (RST),
	.busy     (busy),
	.spi_sck  (spi_sck),
	.spi_cs_n (spi_cs_n),
	.rx_valid (rx_valid),
	.rx_chan  (rx_chan)
);

`default_nettype wire

/* bench/spi_array_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_array_settings.svh"

////////////////////////////////////////////////////////////////////////////
// SPI slave model
////////////////////////////////////////////////////////////////////////////

module spi_slave_model (
	input  logic                  spi_sck,
	input  logic                  cs_n,
	input  logic                  mosi,
	input  spi_array_pkg::word_t  reply,
	output logic                  miso,
	output spi_array_pkg::word_t  captured,
	output int                    n_bits,
	output int                    n_frames
);

	// Reply shifter
	spi_array_pkg::word_t sr = '0;
	logic                 selected = 1'b0;
	logic                 miso_r = 1'b0;
	// Last SPI_WIDTH bits seen on MOSI
	spi_array_pkg::word_t cap = '0;
	int                   bits = 0;
	int                   frames = 0;

	assign miso     = miso_r;
	assign captured = cap;
	assign n_bits   = bits;
	assign n_frames = frames;

	// MISO moves 1 ns after select or a falling SCK
	always @(negedge cs_n or negedge spi_sck) begin
		#1;
		if (!cs_n && !selected) begin
			// New frame, reply MSB first
			sr     = reply;
			frames = frames + 1;
		end else if (!cs_n) begin
			sr = sr << 1;
		end
		selected = !cs_n;
		miso_r   = selected ? sr[`SPI_WIDTH-1] : 1'b0;
	end

	// MOSI taken on the rising edge
	always @(posedge spi_sck) begin
		if (!cs_n) begin
			cap  = {cap[`SPI_WIDTH-2:0], mosi};
			bits = bits + 1;
		end
	end

endmodule

////////////////////////////////////////////////////////////////////////////
// Testbench
////////////////////////////////////////////////////////////////////////////

module spi_array_tb;

	localparam int N_ROWS        = 12;
	localparam int DRAIN_TIMEOUT = 1000;

	// Stimulus row
	typedef struct packed {
		spi_array_pkg::chan_t chan;
		spi_array_pkg::word_t tx;
		spi_array_pkg::word_t reply;
		logic                 drop;
		logic                 wait_prev;
	} row_t;

	// Result still owed by the DUT
	typedef struct packed {
		spi_array_pkg::chan_t chan;
		spi_array_pkg::word_t tx;
		spi_array_pkg::word_t reply;
	} exp_t;

	logic                  CLK50MHZ;
	logic                  RST;
	logic                  start;
	spi_array_pkg::chan_t  start_chan;
	spi_array_pkg::word_t  start_word;
	logic                  start_drop;
	logic [`SPI_N_CH-1:0]  busy;
	logic                  spi_sck;
	logic [`SPI_N_CH-1:0]  spi_cs_n;
	logic [`SPI_N_CH-1:0]  spi_mosi;
	logic [`SPI_N_CH-1:0]  spi_miso;
	logic                  rx_valid;
	spi_array_pkg::chan_t  rx_chan;
	spi_array_pkg::word_t  rx_word;

	spi_array_pkg::word_t  reply_w [`SPI_N_CH];
	spi_array_pkg::word_t  cap_w [`SPI_N_CH];
	int                    bits_w [`SPI_N_CH];
	int                    frames_w [`SPI_N_CH];
	int                    exp_frames [`SPI_N_CH];
	row_t                  tbl [N_ROWS];
	exp_t                  exp_q [$];
	integer                seed;

	spi_array_top UUT (
		.CLK50MHZ   (CLK50MHZ),
		.RST        (RST),
		.start      (start),
		.start_chan (start_chan),
		.start_word (start_word),
		.start_drop (start_drop),
		.busy       (busy),
		.spi_sck    (spi_sck),
		.spi_cs_n   (spi_cs_n),
		.spi_mosi   (spi_mosi),
		.spi_miso   (spi_miso),
		.rx_valid   (rx_valid),
		.rx_chan    (rx_chan),
		.rx_word    (rx_word)
	);

	// One slave per chip select
	for (genvar i = 0; i < `SPI_N_CH; i++) begin : g_slave
		spi_slave_model u_slave (
			.spi_sck  (spi_sck),
			.cs_n     (spi_cs_n[i]),
			.mosi     (spi_mosi[i]),
			.reply    (reply_w[i]),
			.miso     (spi_miso[i]),
			.captured (cap_w[i]),
			.n_bits   (bits_w[i]),
			.n_frames (frames_w[i])
		);
	end

	// 50 MHz
	always #10 CLK50MHZ = ~CLK50MHZ;

	task automatic stop_on_error();
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_word(input string name, input spi_array_pkg::word_t got,
			input spi_array_pkg::word_t want);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, want);
			stop_on_error();
		end
	endtask

	task automatic check_chan(input string name, input spi_array_pkg::chan_t got,
			input spi_array_pkg::chan_t want);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, want);
			stop_on_error();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, want);
			stop_on_error();
		end
	endtask

	// Idle state during and right after reset
	task automatic check_idle_outputs();
		for (int i = 0; i < `SPI_N_CH; i++) begin
			check_flag($sformatf("spi_cs_n[%0d]", i), spi_cs_n[i], 1'b1);
			check_flag($sformatf("busy[%0d]", i), busy[i], 1'b0);
		end
		check_flag("rx_valid", rx_valid, 1'b0);
		check_flag("start_drop", start_drop, 1'b0);
	endtask

	// Only addressed slaves saw frames, each of full length
	task automatic check_frame_counts();
		for (int i = 0; i < `SPI_N_CH; i++) begin
			if (frames_w[i] != exp_frames[i]) begin
				$display("MISMATCH at %0t: slave %0d frame count is %0d, expected %0d",
					$time, i, frames_w[i], exp_frames[i]);
				stop_on_error();
			end
			if (bits_w[i] != `SPI_WIDTH * exp_frames[i]) begin
				$display("MISMATCH at %0t: slave %0d MOSI bit count is %0d, expected %0d",
					$time, i, bits_w[i], `SPI_WIDTH * exp_frames[i]);
				stop_on_error();
			end
		end
	endtask

	task automatic wait_all_done();
		int n;
		n = 0;
		while (exp_q.size() != 0 || busy != '0) begin
			@(posedge CLK50MHZ);
			#1;
			n++;
			if (n > DRAIN_TIMEOUT) begin
				$display("Timeout at %0t: frames still running after %0d cycles",
					$time, DRAIN_TIMEOUT);
				stop_on_error();
			end
		end
		check_frame_counts();
	endtask

	task automatic set_row(input int r, input spi_array_pkg::chan_t c,
			input spi_array_pkg::word_t w, input logic drop, input logic wait_prev);
		tbl[r].chan      = c;
		tbl[r].tx        = w;
		tbl[r].reply     = $random(seed);
		tbl[r].drop      = drop;
		tbl[r].wait_prev = wait_prev;
	endtask

	task automatic build_table();
		// Single frames, each channel in turn
		set_row(0, 2'd0, 32'hA5C3_0F81, 1'b0, 1'b1);
		set_row(1, 2'd1, 32'h8000_0001, 1'b0, 1'b1);
		set_row(2, 2'd2, 32'h1234_5678, 1'b0, 1'b1);
		set_row(3, 2'd3, 32'hFFFF_0000, 1'b0, 1'b1);
		// All four back to back
		set_row(4, 2'd0, 32'h0F0F_F0F0, 1'b0, 1'b1);
		set_row(5, 2'd1, 32'h6B1D_93E4, 1'b0, 1'b0);
		set_row(6, 2'd2, 32'h7E57_C0DE, 1'b0, 1'b0);
		set_row(7, 2'd3, 32'h0123_4567, 1'b0, 1'b0);
		// Second start while the first is in flight
		set_row(8, 2'd2, 32'h3C3C_5A5A, 1'b0, 1'b1);
		set_row(9, 2'd2, 32'h9DD0_4A21, 1'b1, 1'b0);
		// Third start once the channel reports busy
		set_row(10, 2'd2, 32'hC001_D00D, 1'b1, 1'b0);
		// Normal frame after the refusal
		set_row(11, 2'd1, 32'h0000_8001, 1'b0, 1'b1);
	endtask

	// Results come in issue order
	// Frames ending on one tick come out in ascending channel order
	always @(negedge CLK50MHZ) begin : rx_monitor
		exp_t e;
		if (RST === 1'b1 && rx_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("Error at %0t: rx_valid with no frame outstanding", $time);
				stop_on_error();
			end else begin
				e = exp_q.pop_front();
				check_chan("rx_chan", rx_chan, e.chan);
				check_word("rx_word", rx_word, e.reply);
				check_word($sformatf("slave %0d MOSI word", e.chan), cap_w[e.chan], e.tx);
			end
		end
	end

	initial begin
		CLK50MHZ   = 1'b0;
		RST        = 1'b0;
		start      = 1'b0;
		start_chan = '0;
		start_word = '0;
		seed       = 32'h77d6d819;
		for (int i = 0; i < `SPI_N_CH; i++) begin
			reply_w[i]    = '0;
			exp_frames[i] = 0;
		end
		build_table();

		// Reset held for two cycles
		repeat (2) begin
			@(posedge CLK50MHZ);
			#1;
			check_idle_outputs();
		end
		RST = 1'b1;
		@(posedge CLK50MHZ);
		#1;
		check_idle_outputs();

		for (int r = 0; r < N_ROWS; r++) begin
			if (tbl[r].wait_prev) begin
				wait_all_done();
			end
			start      = 1'b1;
			start_chan = tbl[r].chan;
			start_word = tbl[r].tx;
			if (!tbl[r].drop) begin
				reply_w[tbl[r].chan] = tbl[r].reply;
				exp_frames[tbl[r].chan]++;
				exp_q.push_back({tbl[r].chan, tbl[r].tx, tbl[r].reply});
			end
			@(posedge CLK50MHZ);
			#1;
			start = 1'b0;
			// Refusal shows one cycle after the request
			check_flag("start_drop", start_drop, tbl[r].drop);
		end
		wait_all_done();

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+rtl
rtl/spi_array_pkg.sv
rtl/spi_chan_if.sv
rtl/sck_tick_gen.sv
rtl/spi_dispatch.sv
rtl/spi_shift_engine.sv
rtl/spi_collect.sv
rtl/spi_array_top.sv
bench/spi_array_chk.sv
bench/spi_array_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = spi_array_tb
FILELIST  = src.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
